//--- bench/apbTargetModel.sv
`timescale 1ns/100ps

module apbTargetModel import ioBridgePkg::*; (
	input  logic                    CLK,
	input  logic                    arstN,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [apbAddrWidth-1:0] paddr,
	input  logic [15:0]             pwdata,
	input  logic [1:0]              pstrb,
	output logic [15:0]             prdata,
	output logic                    pready,
	output logic                    pslverr
);

	logic [15:0] mem [64];
	logic [1:0]  waitCnt;
	logic [5:0]  idx;
	logic        errWin;
	integer      seed = 32'hb44;

	// Word index into the register memory
	assign idx    = paddr[6:1];
	// Upper quarter of the I/O space answers with an error
	assign errWin = paddr[20:19] == 2'b11;

	// Fill pattern built from every index bit
	initial begin
		for (int i = 0; i < 64; i++) begin
			mem[i] = {2'b11, 6'(i), 2'b00, 6'(~i)};
		end
	end

	// Responses change on the falling edge, away from the DUT sampling edge
	always @(negedge CLK or negedge arstN) begin
		if (!arstN) begin
			prdata  <= 16'h0000;
			pready  <= 1'b0;
			pslverr <= 1'b0;
			waitCnt <= 2'd0;
		end else if (psel && !penable) begin
			// Setup phase
			// Pick 0 to 3 wait states for this transfer
			waitCnt <= 2'($random(seed));
			pready  <= 1'b0;
		end else if (psel && penable && !pready) begin
			if (waitCnt != 2'd0) begin
				waitCnt <= waitCnt - 2'd1;
			end else begin
				pready  <= 1'b1;
				pslverr <= errWin;
				prdata  <= errWin ? 16'h0000 : mem[idx];
				// Byte lanes follow pstrb
				if (pwrite && !errWin) begin
					if (pstrb[0]) begin
						mem[idx][7:0] <= pwdata[7:0];
					end
					if (pstrb[1]) begin
						mem[idx][15:8] <= pwdata[15:8];
					end
				end
			end
		end else begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end
	end

endmodule

//--- bench/ioBridgeTb.sv
`timescale 1ns/100ps

module ioBridgeTb import ioBridgePkg::*; ();

	// Watchdog budget
	// Reset plus every CPU access at its worst length, four times over
	localparam int resetCycles       = 8;
	localparam int accessCount       = 11;
	localparam int worstAccessCycles = 45;
	localparam int watchdogCycles    = resetCycles + accessCount * worstAccessCycles * 4;

	logic                    CLK;
	logic                    arstN;
	fsbCycle_t               fsb;
	logic [15:0]             rdata;
	logic                    ready;
	logic                    berrN;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [apbAddrWidth-1:0] paddr;
	logic [15:0]             pwdata;
	logic [1:0]              pstrb;
	logic [15:0]             prdata;
	logic                    pready;
	logic                    pslverr;

	int errors      = 0;
	int testErrors  = 0;
	int testsRun    = 0;
	int testsFailed = 0;
	// Bus monitors
	int apbDone     = 0;
	int pselCycles  = 0;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	ioBridgeTop i_dut (
		.CLK(CLK), .arstN(arstN), .fsb(fsb), .rdata(rdata), .ready(ready), .berrN(berrN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pstrb(pstrb), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	apbTargetModel i_apb (
		.CLK(CLK), .arstN(arstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
		.pready(pready), .pslverr(pslverr)
	);

	// Completed APB transfers and cycles with psel high
	always @(posedge CLK) begin
		if (psel && penable && pready) begin
			apbDone <= apbDone + 1;
		end
		if (psel) begin
			pselCycles <= pselCycles + 1;
		end
	end

	// Old word with the enabled lanes replaced, lanes as {upper, lower}
	function automatic logic [15:0] mergeLanes(input logic [15:0] oldWord,
		input logic [15:0] newWord, input logic [1:0] lanes);
		logic [15:0] word;
		word = oldWord;
		if (lanes[0]) begin
			word[7:0] = newWord[7:0];
		end
		if (lanes[1]) begin
			word[15:8] = newWord[15:8];
		end
		return word;
	endfunction

	task automatic checkData(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkTerm(input logic gotReady, input logic gotBerrN,
		input logic expReady, input logic expBerrN, input string what);
		if (gotReady !== expReady || gotBerrN !== expBerrN) begin
			$display("FAIL at time %0t: %s ended with ready=%b berrN=%b, expected ready=%b berrN=%b",
				$time, what, gotReady, gotBerrN, expReady, expBerrN);
			errors++;
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAIL at time %0t: %s, got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// One CPU cycle, held until ready or bus error
	task automatic busCycle(input logic write, input logic [fsbAddrWidth-1:0] addr,
		input logic [15:0] data, input logic [1:0] lanes,
		output logic [15:0] rd, output logic gotReady, output logic gotBerrN);
		@(negedge CLK);
		fsb.weN   = !write;
		fsb.ldsN  = !lanes[0];
		fsb.udsN  = !lanes[1];
		fsb.addr  = addr;
		fsb.wdata = data;
		fsb.asN   = 1'b0;
		@(negedge CLK);
		while (ready == 1'b0 && berrN == 1'b1) begin
			@(negedge CLK);
		end
		rd       = rdata;
		gotReady = ready;
		gotBerrN = berrN;
		// CPU ends the cycle
		fsb.asN  = 1'b1;
		fsb.weN  = 1'b1;
		fsb.ldsN = 1'b1;
		fsb.udsN = 1'b1;
	endtask

	task automatic cpuWrite(input logic [fsbAddrWidth-1:0] addr, input logic [15:0] data,
		input logic [1:0] lanes, output logic gotReady, output logic gotBerrN);
		logic [15:0] unused;
		busCycle(1'b1, addr, data, lanes, unused, gotReady, gotBerrN);
	endtask

	task automatic cpuRead(input logic [fsbAddrWidth-1:0] addr, output logic [15:0] rd,
		output logic gotReady, output logic gotBerrN);
		busCycle(1'b0, addr, 16'h0000, 2'b11, rd, gotReady, gotBerrN);
	endtask

	task automatic testResetState();
		@(negedge CLK);
		checkTerm(ready, berrN, 1'b0, 1'b1, "idle bus after reset");
		checkBit(psel, 1'b0, "psel after reset");
		checkBit(penable, 1'b0, "penable after reset");
	endtask

	task automatic testWriteRead();
		logic [15:0] d;
		logic        r;
		logic        b;
		cpuWrite(23'h400004, 16'h5a3c, 2'b11, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "non-posted write");
		cpuRead(23'h400004, d, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "read back");
		checkData(d, 16'h5a3c, "read back data");
	endtask

	task automatic testPostedOrder();
		logic [15:0] d;
		logic        r;
		logic        b;
		int          base;
		base = apbDone;
		// Back to back into the post window
		cpuWrite(23'h480010, 16'hc001, 2'b11, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "first posted write");
		checkBit(apbDone == base, 1'b1, "first posted write released before its APB end");
		cpuWrite(23'h480011, 16'hc002, 2'b11, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "second posted write");
		checkBit(apbDone - base < 2, 1'b1, "second posted write released before its APB end");
		cpuRead(23'h480010, d, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "read of first posted word");
		checkData(d, 16'hc001, "first posted word");
		cpuRead(23'h480011, d, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "read of second posted word");
		checkData(d, 16'hc002, "second posted word");
	endtask

	task automatic testByteLane();
		logic [15:0] d;
		logic        r;
		logic        b;
		cpuWrite(23'h400020, 16'h1234, 2'b11, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "full word write");
		// Low lane only
		cpuWrite(23'h400020, 16'h56ab, 2'b01, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "low byte write");
		cpuRead(23'h400020, d, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "read after byte write");
		checkData(d, mergeLanes(16'h1234, 16'h56ab, 2'b01), "merged word");
	endtask

	task automatic testBusError();
		logic [15:0] d;
		logic        r;
		logic        b;
		cpuRead(23'h4c0008, d, r, b);
		checkTerm(r, b, 1'b0, 1'b0, "read in error quarter");
	endtask

	task automatic testOutsideIo();
		logic [15:0] d;
		logic        r;
		logic        b;
		int          base;
		base = pselCycles;
		cpuRead(23'h100040, d, r, b);
		checkTerm(r, b, 1'b1, 1'b1, "access outside I/O space");
		checkBit(pselCycles == base, 1'b1, "psel stayed low outside I/O space");
	endtask

	// Result of the test just run
	task automatic reportTest(input string name);
		testsRun++;
		if (errors == testErrors) begin
			$display("test %s ok", name);
		end else begin
			$display("test %s failed with %0d errors", name, errors - testErrors);
			testsFailed++;
		end
		testErrors = errors;
	endtask

	initial begin
		arstN     = 1'b0;
		fsb.asN   = 1'b1;
		fsb.weN   = 1'b1;
		fsb.ldsN  = 1'b1;
		fsb.udsN  = 1'b1;
		fsb.addr  = '0;
		fsb.wdata = 16'h0000;
		repeat (resetCycles) @(negedge CLK);
		arstN = 1'b1;
		testResetState();
		reportTest("reset state");
		testWriteRead();
		reportTest("write then read");
		testPostedOrder();
		reportTest("posted write order");
		testByteLane();
		reportTest("low byte lane");
		testBusError();
		reportTest("bus error");
		testOutsideIo();
		reportTest("outside I/O space");
		$display("%0d tests run, %0d failed, %0d failed checks", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Stops a cycle that never terminates
	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, the bridge stopped answering",
			watchdogCycles);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ioBridgeTb -f sources.f

output=$(./obj_dir/VioBridgeTb)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1

//--- sources.f
verilog/ioBridgePkg.sv
verilog/ioBridgeSlave.sv
verilog/postedWriteFifo.sv
verilog/ioBusMaster.sv
verilog/ioBridgeTop.sv
bench/apbTargetModel.sv
bench/ioBridgeTb.sv

//--- verilog/ioBridgePkg.sv
package ioBridgePkg;

	// FSB carries word addresses
	localparam int fsbAddrWidth = 23;

	// APB carries byte addresses, one bit wider
	localparam int apbAddrWidth = 24;

	// I/O space decode
	// Selected when the masked word address matches the base
	localparam logic [fsbAddrWidth-1:0] ioBase = 23'h400000;
	localparam logic [fsbAddrWidth-1:0] ioMask = 23'h700000;

	// Posted-write window, upper half of the I/O space
	localparam logic [fsbAddrWidth-1:0] postBase = 23'h480000;
	localparam logic [fsbAddrWidth-1:0] postMask = 23'h780000;

	// CPU side of one bus cycle
	// Strobes are active low as on the 68000 pins
	typedef struct packed {
		logic                    asN;
		logic                    weN;
		logic                    ldsN;
		logic                    udsN;
		logic [fsbAddrWidth-1:0] addr;
		logic [15:0]             wdata;
	} fsbCycle_t;

	// One queued transfer
	// Same layout in both FIFO levels and at the master input
	typedef struct packed {
		logic [fsbAddrWidth-1:0] addr;
		logic [15:0]             wdata;
		logic                    write;
		// Lane enables, active high
		logic                    lowByte;
		logic                    upByte;
	} ioReq_t;

	// Transfer state of the bridge slave
	typedef enum logic [1:0] {
		tsIdle,
		tsStart,
		tsWaitAct,
		tsWaitDone
	} xferState_t;

endpackage

//--- verilog/ioBridgeSlave.sv
`timescale 1ns/100ps

module ioBridgeSlave import ioBridgePkg::*; (
	input  logic      CLK,
	input  logic      arstN,
	// CPU bus, sampled on CLK
	input  fsbCycle_t fsb,
	output logic      ready,
	output logic      berrN,
	// FIFO level controls
	output logic      loadPrimary,
	output logic      loadSecondary,
	output logic      releaseSecondary,
	output logic      selSecondary,
	input  logic      secondaryFull,
	// Handshake with the I/O bus master
	output logic      ioReq,
	input  logic      ioAct,
	input  logic      ioErr
);

	xferState_t state;
	logic       cycleAct;
	logic       ioSel;
	logic       postSel;
	logic       postedCycle;
	logic       ioStart;
	logic       once;
	logic       ioActR;
	logic       xferDone;

	// Master activity registered once before use
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ioActR <= 1'b0;
		end else begin
			ioActR <= ioAct;
		end
	end

	// Address decode
	assign cycleAct    = !fsb.asN;
	assign ioSel       = (fsb.addr & ioMask) == ioBase;
	assign postSel     = (fsb.addr & postMask) == postBase;
	assign postedCycle = ioSel && postSel && !fsb.weN;
	// Only one request per CPU cycle
	assign ioStart     = cycleAct && ioSel && !once;

	// Primary level follows its source while starting
	assign loadPrimary      = state == tsStart;
	// Secondary entry moves to primary and frees its level
	assign releaseSecondary = loadPrimary && selSecondary;
	// Queue a posted write behind the transfer in flight
	assign loadSecondary    = (state != tsIdle) && ioStart && postedCycle && !secondaryFull;

	// Transfer state machine
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state        <= tsIdle;
			ioReq        <= 1'b0;
			selSecondary <= 1'b0;
		end else begin
			case (state)
				tsIdle: begin
					// Queued write drains before any new cycle
					if (secondaryFull) begin
						state        <= tsStart;
						ioReq        <= 1'b1;
						selSecondary <= 1'b1;
					end else if (ioStart) begin
						state        <= tsStart;
						ioReq        <= 1'b1;
						selSecondary <= 1'b0;
					end
				end
				// Primary loads here while the request is held
				tsStart: state <= tsWaitAct;
				tsWaitAct: begin
					// Master took the request
					if (ioActR) begin
						state <= tsWaitDone;
						ioReq <= 1'b0;
					end
				end
				tsWaitDone: begin
					if (!ioActR) begin
						state <= tsIdle;
					end
				end
			endcase
		end
	end

	// Set once the current CPU cycle has a transfer submitted or queued
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			once <= 1'b0;
		end else if (!cycleAct) begin
			once <= 1'b0;
		end else if ((state == tsIdle && !secondaryFull && ioStart) || loadSecondary) begin
			once <= 1'b1;
		end
	end

	// All earlier transfers finished and own transfer complete
	assign xferDone = once && !secondaryFull &&
		(state == tsIdle || (state == tsWaitDone && !ioActR));

	// Cycle termination
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ready <= 1'b0;
			berrN <= 1'b1;
		end else if (!cycleAct) begin
			ready <= 1'b0;
			berrN <= 1'b1;
		end else if (!ioSel) begin
			// Not ours so the cycle ends at once
			ready <= 1'b1;
		end else if (once && postedCycle) begin
			// Posted write ends when queued and its errors are dropped
			ready <= 1'b1;
		end else if (xferDone) begin
			ready <= !ioErr;
			berrN <= !ioErr;
		end
	end

	// No request while idle
	assert property (@(posedge CLK) disable iff (!arstN) state == tsIdle |-> !ioReq);
	// Queued write leaves the secondary level occupied
	assert property (@(posedge CLK) disable iff (!arstN) loadSecondary |=> secondaryFull);

endmodule

//--- verilog/ioBridgeTop.sv
`timescale 1ns/100ps

module ioBridgeTop import ioBridgePkg::*; (
	input  logic                    CLK,
	input  logic                    arstN,
	// CPU bus
	input  fsbCycle_t               fsb,
	output logic [15:0]             rdata,
	output logic                    ready,
	output logic                    berrN,
	// APB
	output logic                    psel,
	output logic                    penable,
	output logic                    pwrite,
	output logic [apbAddrWidth-1:0] paddr,
	output logic [15:0]             pwdata,
	output logic [1:0]              pstrb,
	input  logic [15:0]             prdata,
	input  logic                    pready,
	input  logic                    pslverr
);

	// FIFO level controls
	logic   loadPrimary;
	logic   loadSecondary;
	logic   releaseSecondary;
	logic   selSecondary;
	logic   secondaryFull;
	// Slave to master handshake
	logic   ioReq;
	logic   ioAct;
	logic   ioErr;
	ioReq_t primary;

	ioBridgeSlave i_slave (
		.CLK(CLK), .arstN(arstN), .fsb(fsb), .ready(ready), .berrN(berrN),
		.loadPrimary(loadPrimary), .loadSecondary(loadSecondary),
		.releaseSecondary(releaseSecondary), .selSecondary(selSecondary),
		.secondaryFull(secondaryFull), .ioReq(ioReq), .ioAct(ioAct), .ioErr(ioErr)
	);

	postedWriteFifo i_fifo (
		.CLK(CLK), .arstN(arstN), .fsb(fsb),
		.loadPrimary(loadPrimary), .loadSecondary(loadSecondary),
		.releaseSecondary(releaseSecondary), .selSecondary(selSecondary),
		.secondaryFull(secondaryFull), .primary(primary)
	);

	// Read data comes back from the master
	ioBusMaster i_master (
		.CLK(CLK), .arstN(arstN), .req(primary), .ioReq(ioReq), .ioAct(ioAct),
		.ioErr(ioErr), .ioRdata(rdata), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

endmodule

//--- verilog/ioBusMaster.sv
`timescale 1ns/100ps

module ioBusMaster import ioBridgePkg::*; (
	input  logic                    CLK,
	input  logic                    arstN,
	// Transfer from the primary FIFO level
	input  ioReq_t                  req,
	// Handshake with the bridge slave
	input  logic                    ioReq,
	output logic                    ioAct,
	output logic                    ioErr,
	output logic [15:0]             ioRdata,
	// APB requester
	output logic                    psel,
	output logic                    penable,
	output logic                    pwrite,
	output logic [apbAddrWidth-1:0] paddr,
	output logic [15:0]             pwdata,
	output logic [1:0]              pstrb,
	input  logic [15:0]             prdata,
	input  logic                    pready,
	input  logic                    pslverr
);

	logic xferEnd;

	// Access phase completes this cycle
	assign xferEnd = psel && penable && pready;

	// APB sequencer
	// Idle is psel low, setup is psel alone, access adds penable
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			psel    <= 1'b0;
			penable <= 1'b0;
		end else if (!psel) begin
			if (ioReq) begin
				psel <= 1'b1;
			end
		end else if (!penable) begin
			penable <= 1'b1;
		end else if (pready) begin
			psel    <= 1'b0;
			penable <= 1'b0;
		end
	end

	// Busy from setup through the pready cycle
	assign ioAct = psel;

	// Error status of the last transfer
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ioErr <= 1'b0;
		end else if (xferEnd) begin
			ioErr <= pslverr;
		end
	end

	// Read data held for the slave
	always_ff @(posedge CLK) begin
		if (xferEnd) begin
			ioRdata <= prdata;
		end
	end

	// Request fields come straight from the primary level
	// It does not change while a transfer runs
	assign paddr  = {req.addr, 1'b0};
	assign pwrite = req.write;
	assign pwdata = req.wdata;
	// Strobes only on writes
	assign pstrb  = req.write ? {req.upByte, req.lowByte} : 2'b00;

	// Access phase only inside a selected transfer
	assert property (@(posedge CLK) disable iff (!arstN) penable |-> psel);
	// Address held through wait states
	assert property (@(posedge CLK) disable iff (!arstN)
		penable && !pready |=> $stable(paddr));

endmodule

//--- verilog/postedWriteFifo.sv
`timescale 1ns/100ps

module postedWriteFifo import ioBridgePkg::*; (
	input  logic      CLK,
	input  logic      arstN,
	// CPU bus fields to be latched
	input  fsbCycle_t fsb,
	// Level controls from the bridge slave
	input  logic      loadPrimary,
	input  logic      loadSecondary,
	input  logic      releaseSecondary,
	input  logic      selSecondary,
	output logic      secondaryFull,
	// Entry seen by the master
	output ioReq_t    primary
);

	ioReq_t fsbEntry;
	ioReq_t secondary;

	// Current CPU cycle as an entry
	// Active-low strobes become lane enables
	always_comb begin
		fsbEntry.addr    = fsb.addr;
		fsbEntry.wdata   = fsb.wdata;
		fsbEntry.write   = !fsb.weN;
		fsbEntry.lowByte = !fsb.ldsN;
		fsbEntry.upByte  = !fsb.udsN;
	end

	// Secondary level, write waiting behind the one on APB
	always_ff @(posedge CLK) begin
		if (loadSecondary) begin
			secondary <= fsbEntry;
		end
	end

	// Occupancy of the secondary level
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			secondaryFull <= 1'b0;
		end else if (loadSecondary) begin
			secondaryFull <= 1'b1;
		end else if (releaseSecondary) begin
			secondaryFull <= 1'b0;
		end
	end

	// Primary level
	// Source is the queued entry or the live CPU cycle
	always_ff @(posedge CLK) begin
		if (loadPrimary) begin
			primary <= selSecondary ? secondary : fsbEntry;
		end
	end

	// Every entry handed to the master drives at least one lane
	assert property (@(posedge CLK) disable iff (!arstN)
		loadPrimary |=> (primary.lowByte || primary.upByte));

endmodule
